//--- hw/frame_dma_config.svh
//====================
// Frame DMA configuration
// Frame geometry, FIFO depth and Wishbone widths
//====================
`ifndef FRAME_DMA_CONFIG_SVH
`define FRAME_DMA_CONFIG_SVH

// Simulation frame size (1280 x 720 on the board)
`define H_NUM        16
`define V_NUM        4
`define PIX_PER_WORD 8
`define FRAME_WORDS  ((`H_NUM * `V_NUM) / `PIX_PER_WORD)

`define FIFO_DEPTH   16     // Power of two
`define WB_ADR_W     2
`define WB_DAT_W     32

`endif

//--- hw/cam_pkg.sv
//====================
// Camera data types
//====================
`include "frame_dma_config.svh"

package cam_pkg;

	// One byte from the sensor bus
	typedef logic [7:0] cam_byte_t;

	// RGB565 pixel
	typedef logic [15:0] pixel_t;

	// Eight pixels per DMA word, pixel 0 in the low bits
	typedef pixel_t [`PIX_PER_WORD-1:0] frame_word_t;

endpackage

//--- hw/dma_pkg.sv
//====================
// Host read port types
//====================
`include "frame_dma_config.svh"

package dma_pkg;

	// Frame read session
	typedef enum logic {
		SESS_IDLE   = 1'b0,
		SESS_ACTIVE = 1'b1
	} session_state_t;

	// Wishbone register map
	typedef enum logic [`WB_ADR_W-1:0] {
		REG_DATA   = 2'd0,
		REG_STATUS = 2'd1
	} reg_addr_t;

	// Words read in the current session
	typedef logic [16:0] word_count_t;

endpackage

//--- hw/word_stream_if.sv
//====================
// Frame word stream between stages
//====================
`timescale 1ns/10ps

interface word_stream_if;
	import cam_pkg::*;

	logic        valid;
	logic        ready;
	frame_word_t data;
	logic        sof;      // First word of a frame

	modport src (
		output valid, data, sof,
		input  ready
	);

	modport snk (
		input  valid, data, sof,
		output ready
	);

endinterface

//--- hw/cam_capture.sv
//====================
// Camera capture
// Registers the sensor bus and packs RGB565 pixels into frame words
//====================
`timescale 1ns/10ps
`include "frame_dma_config.svh"

module cam_capture (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_cam_vsync,
	input  logic               i_cam_href,
	input  cam_pkg::cam_byte_t i_cam_data,
	word_stream_if.src         o_word
);
	import cam_pkg::*;

	localparam int PIX_W = $clog2(`PIX_PER_WORD);

	cam_byte_t   data_d0;
	logic        href_d0;
	logic        vsync_d0;
	logic        vsync_d1;
	logic        vs_rise;
	logic        byte_phase;       // High when the low byte is next
	logic [PIX_W-1:0] pix_cnt;
	cam_byte_t   hi_byte;
	frame_word_t word_buf;
	logic        sof_armed;
	logic        word_done;
	logic        valid_q;
	logic        sof_q;

	assign vs_rise   = vsync_d0 & ~vsync_d1;
	assign word_done = href_d0 & ~vs_rise & byte_phase &
		(pix_cnt == PIX_W'(`PIX_PER_WORD - 1));

	//====================
	// Control
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			href_d0    <= 1'b0;
			vsync_d0   <= 1'b0;
			vsync_d1   <= 1'b0;
			byte_phase <= 1'b0;
			pix_cnt    <= '0;
			sof_armed  <= 1'b0;
			valid_q    <= 1'b0;
			sof_q      <= 1'b0;
		end else begin
			href_d0  <= i_cam_href;
			vsync_d0 <= i_cam_vsync;
			vsync_d1 <= vsync_d0;
			valid_q  <= word_done;    // One cycle pulse
			if (vs_rise) begin
				byte_phase <= 1'b0;
				pix_cnt    <= '0;
				sof_armed  <= 1'b1;
			end else if (href_d0) begin
				byte_phase <= ~byte_phase;
				if (byte_phase)
					pix_cnt <= pix_cnt + 1'b1;   // Wraps at word end
				if (word_done) begin
					sof_q     <= sof_armed;
					sof_armed <= 1'b0;
				end
			end
		end
	end

	// Byte pairing, high byte first
	always_ff @(posedge i_clk) begin
		data_d0 <= i_cam_data;
		if (href_d0 && !vs_rise) begin
			if (!byte_phase)
				hi_byte <= data_d0;
			else
				word_buf[pix_cnt] <= {hi_byte, data_d0};
		end
	end

	assign o_word.valid = valid_q;
	assign o_word.data  = word_buf;
	assign o_word.sof   = sof_q;

endmodule

//--- hw/frame_fifo.sv
//====================
// Frame word FIFO
// FWFT buffer standing in for the frame store
//====================
`timescale 1ns/10ps
`include "frame_dma_config.svh"

module frame_fifo (
	input  logic       i_clk,
	input  logic       i_rst_n,
	word_stream_if.snk i_wr,
	word_stream_if.src o_rd,
	input  logic       i_ovf_clear,
	output logic       o_overflow
);
	import cam_pkg::*;

	localparam int AW = $clog2(`FIFO_DEPTH);

	frame_word_t mem     [`FIFO_DEPTH];
	logic        sof_mem [`FIFO_DEPTH];
	logic [AW:0] wr_ptr;      // Extra bit tells full from empty
	logic [AW:0] rd_ptr;
	logic        full;
	logic        empty;
	logic        push;
	logic        pop;

	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign empty = (wr_ptr == rd_ptr);
	assign push  = i_wr.valid & ~full;
	assign pop   = o_rd.valid & o_rd.ready;

	assign i_wr.ready = ~full;
	assign o_rd.valid = ~empty;
	assign o_rd.data  = mem[rd_ptr[AW-1:0]];
	assign o_rd.sof   = sof_mem[rd_ptr[AW-1:0]];

	always_ff @(posedge i_clk) begin
		if (push) begin
			mem[wr_ptr[AW-1:0]]     <= i_wr.data;
			sof_mem[wr_ptr[AW-1:0]] <= i_wr.sof;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			o_overflow <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (i_wr.valid && full)
				o_overflow <= 1'b1;        // Word dropped
			else if (i_ovf_clear)
				o_overflow <= 1'b0;
		end
	end

endmodule

//--- hw/dma_reader.sv
//====================
// Host read port
// Wishbone slave serving frame words in aligned read sessions
//====================
`timescale 1ns/10ps
`include "frame_dma_config.svh"

module dma_reader (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	word_stream_if.snk           i_word,
	input  logic                 i_overflow,
	output logic                 o_ovf_clear,
	input  logic                 i_wb_cyc,
	input  logic                 i_wb_stb,
	input  logic                 i_wb_we,
	input  logic [`WB_ADR_W-1:0] i_wb_adr,
	input  logic [`WB_DAT_W-1:0] i_wb_dat,
	output logic [`WB_DAT_W-1:0] o_wb_dat,
	output logic                 o_wb_ack
);
	import dma_pkg::*;

	session_state_t state;
	word_count_t    count;
	reg_addr_t      adr;
	logic [1:0]     lane_q;       // Four 32-bit lanes per word
	logic           last_lane;
	logic           req;
	logic           data_rd;
	logic           data_go;
	logic           reg_go;
	logic           discard;
	logic           pop;
	logic           end_of_frame;
	logic [$bits(cam_pkg::frame_word_t)-1:0] head_flat;
	logic [`WB_DAT_W-1:0] status_word;

	//====================
	// Request decode
	assign adr     = reg_addr_t'(i_wb_adr);
	assign req     = i_wb_cyc & i_wb_stb & ~o_wb_ack;   // Held until ack seen
	assign data_rd = req & ~i_wb_we & (adr == REG_DATA);
	assign reg_go  = req & (i_wb_we | (adr != REG_DATA));

	// Frame alignment while idle
	assign discard = (state == SESS_IDLE) & i_word.valid & ~i_word.sof;
	assign data_go = data_rd & i_word.valid & ~discard;   // Else stall the host

	assign last_lane    = (lane_q == 2'd3);
	assign end_of_frame = (count == word_count_t'(`FRAME_WORDS - 1));
	assign pop          = discard | (data_go & last_lane);
	assign i_word.ready = pop;

	assign head_flat   = i_word.data;
	assign status_word = {i_overflow, (state == SESS_ACTIVE), 13'd0, count};
	assign o_ovf_clear = reg_go & i_wb_we & (adr == REG_STATUS) & i_wb_dat[31];

	//====================
	// Session FSM and word counter
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state    <= SESS_IDLE;
			count    <= '0;
			lane_q   <= '0;
			o_wb_ack <= 1'b0;
		end else begin
			o_wb_ack <= data_go | reg_go;
			if (data_go) begin
				lane_q <= lane_q + 1'b1;
				state  <= SESS_ACTIVE;      // Head is a sof word when idle
				if (last_lane) begin
					if (end_of_frame) begin
						state <= SESS_IDLE;
						count <= '0;
					end else begin
						count <= count + 1'b1;
					end
				end
			end
		end
	end

	// Read data, lane 0 first
	always_ff @(posedge i_clk) begin
		if (data_go)
			o_wb_dat <= head_flat[{lane_q, 5'd0} +: `WB_DAT_W];
		else if (reg_go)
			o_wb_dat <= status_word;
	end

endmodule

//--- hw/cam_dma_top.sv
//====================
// Camera to host DMA top
// Capture, frame FIFO and Wishbone reader on pclk_div2
//====================
`timescale 1ns/10ps
`include "frame_dma_config.svh"

module cam_dma_top (
	input  logic                 i_clk,         // pclk_div2
	input  logic                 i_rst_n,       // core_rst_n
	input  logic                 i_cam_vsync,
	input  logic                 i_cam_href,
	input  cam_pkg::cam_byte_t   i_cam_data,
	input  logic                 i_wb_cyc,
	input  logic                 i_wb_stb,
	input  logic                 i_wb_we,
	input  logic [`WB_ADR_W-1:0] i_wb_adr,
	input  logic [`WB_DAT_W-1:0] i_wb_dat,
	output logic [`WB_DAT_W-1:0] o_wb_dat,
	output logic                 o_wb_ack
);

	logic overflow;
	logic ovf_clear;

	word_stream_if cap_if ();     // Capture to FIFO
	word_stream_if rd_if ();      // FIFO to reader

	cam_capture u_cam_capture (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_cam_vsync (i_cam_vsync),
		.i_cam_href  (i_cam_href),
		.i_cam_data  (i_cam_data),
		.o_word      (cap_if.src)
	);

	frame_fifo u_frame_fifo (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_wr        (cap_if.snk),
		.o_rd        (rd_if.src),
		.i_ovf_clear (ovf_clear),
		.o_overflow  (overflow)
	);

	dma_reader u_dma_reader (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_word      (rd_if.snk),
		.i_overflow  (overflow),
		.o_ovf_clear (ovf_clear),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_adr    (i_wb_adr),
		.i_wb_dat    (i_wb_dat),
		.o_wb_dat    (o_wb_dat),
		.o_wb_ack    (o_wb_ack)
	);

endmodule

//--- testbench/tb_cam_dma.sv
//====================
// Testbench for the camera to host DMA path
//====================
`timescale 1ns/10ps
`include "frame_dma_config.svh"

module tb_cam_dma;
	import cam_pkg::*;
	import dma_pkg::*;

	localparam int WORD_BYTES  = 2 * `PIX_PER_WORD;
	localparam int LINE_GAP    = 4;                 // Blanking cycles after each line
	localparam longint STREAM_NS = 4 * `FRAME_WORDS * 16 * 4 * 100;
	localparam longint HOST_NS   = 4 * `FRAME_WORDS * 4 * 4 * 100;

	logic        pclk_div2;
	logic        core_rst_n;
	logic        cam_vsync;
	logic        cam_href;
	cam_byte_t   cam_data;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [1:0]  wb_adr;
	logic [31:0] wb_dat;
	logic [31:0] wb_rdat;
	logic        wb_ack;

	logic [31:0]  rng_state;
	logic [127:0] exp_q [$];     // Reference words still to be read
	logic [31:0]  rd_q [$];      // DATA lanes from the host side
	logic [127:0] exp_word;
	int           lane_idx;

	cam_dma_top dut0 (
		.i_clk       (pclk_div2),
		.i_rst_n     (core_rst_n),
		.i_cam_vsync (cam_vsync),
		.i_cam_href  (cam_href),
		.i_cam_data  (cam_data),
		.i_wb_cyc    (wb_cyc),
		.i_wb_stb    (wb_stb),
		.i_wb_we     (wb_we),
		.i_wb_adr    (wb_adr),
		.i_wb_dat    (wb_dat),
		.o_wb_dat    (wb_rdat),
		.o_wb_ack    (wb_ack)
	);

	always #50 pclk_div2 = ~pclk_div2;

	//====================
	// Reference model
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Byte pairs form pixels, first byte high, pixel 0 in the low bits
	function automatic logic [127:0] pack_word(input cam_byte_t b [WORD_BYTES]);
		logic [127:0] w;
		for (int i = 0; i < `PIX_PER_WORD; i++)
			w[16*i +: 16] = {b[2*i], b[2*i+1]};
		return w;
	endfunction

	function automatic logic [31:0] status_value(input logic ovf, input logic act,
		input logic [16:0] cnt);
		logic [31:0] s;
		s       = 32'd0;
		s[31]   = ovf;
		s[30]   = act;
		s[16:0] = cnt;
		return s;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	//====================
	// Camera side
	task automatic send_line(input bit keep);
		cam_byte_t wbytes [WORD_BYTES];
		for (int i = 0; i < 2 * `H_NUM; i++) begin
			@(negedge pclk_div2);
			rng_state = lcg_step(rng_state);
			wbytes[i % WORD_BYTES] = rng_state[31:24];
			cam_href = 1'b1;
			cam_data = rng_state[31:24];
			if (keep && (i % WORD_BYTES) == WORD_BYTES - 1)
				exp_q.push_back(pack_word(wbytes));
		end
		@(negedge pclk_div2);
		cam_href = 1'b0;
		repeat (LINE_GAP - 1) @(negedge pclk_div2);
	endtask

	task automatic send_frame(input bit keep);
		@(negedge pclk_div2);
		cam_vsync = 1'b1;      // Rising edge starts the frame
		repeat (4) @(negedge pclk_div2);
		cam_vsync = 1'b0;
		repeat (3) @(negedge pclk_div2);
		for (int l = 0; l < `V_NUM; l++)
			send_line(keep);
	endtask

	//====================
	// Host side
	task automatic read_reg(input logic [1:0] adr, output logic [31:0] data);
		@(negedge pclk_div2);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		@(negedge pclk_div2);
		while (!wb_ack)
			@(negedge pclk_div2);      // DATA may stall until a word arrives
		data   = wb_rdat;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic write_reg(input logic [1:0] adr, input logic [31:0] data);
		@(negedge pclk_div2);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b1;
		wb_adr = adr;
		wb_dat = data;
		@(negedge pclk_div2);
		while (!wb_ack)
			@(negedge pclk_div2);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic read_words(input int n);
		logic [31:0] lane;
		for (int i = 0; i < 4 * n; i++) begin
			read_reg(REG_DATA, lane);
			rd_q.push_back(lane);
		end
	endtask

	task automatic expect_status(input logic ovf, input logic act, input logic [16:0] cnt);
		logic [31:0] data;
		read_reg(REG_STATUS, data);
		check_value("o_wb_dat status", data, status_value(ovf, act, cnt));
	endtask

	task automatic apply_reset();
		@(negedge pclk_div2);
		core_rst_n = 1'b0;
		repeat (4) @(negedge pclk_div2);
		core_rst_n = 1'b1;
	endtask

	// Compare host lanes with the reference words, lane 0 first
	initial begin
		lane_idx = 0;
		forever begin
			@(negedge pclk_div2);
			while (rd_q.size() > 0) begin
				if (exp_q.size() == 0) begin
					$display("DATA read returned a word that was never expected");
					$display("STATUS: FAIL");
					$fatal(1, "Unexpected read data");
				end else begin
					exp_word = exp_q[0];
					check_value("o_wb_dat data", rd_q.pop_front(), exp_word[32*lane_idx +: 32]);
					if (lane_idx == 3) begin
						exp_q.pop_front();
						lane_idx = 0;
					end else begin
						lane_idx = lane_idx + 1;
					end
				end
			end
		end
	end

	// Watchdog sized from the camera stream plus host reads
	initial begin
		#(STREAM_NS + HOST_NS);
		$display("Timeout: the tests did not finish in time");
		$display("STATUS: FAIL");
		$fatal(1, "Watchdog expired");
	end

	//====================
	// Test sequence
	initial begin
		pclk_div2  = 1'b0;
		core_rst_n = 1'b0;
		cam_vsync  = 1'b0;
		cam_href   = 1'b0;
		cam_data   = '0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat     = '0;
		rng_state  = 32'h18f;
		apply_reset();

		// After reset: no ack without stb, status is zero
		wb_cyc = 1'b1;
		repeat (6) begin
			@(negedge pclk_div2);
			check_value("o_wb_ack", {31'd0, wb_ack}, 32'd0);
		end
		wb_cyc = 1'b0;
		expect_status(1'b0, 1'b0, 17'd0);

		// One frame with reads issued before data exists
		fork
			send_frame(1'b1);
			begin
				read_words(4);
				expect_status(1'b0, 1'b1, 17'd4);
				read_words(`FRAME_WORDS - 4);
				expect_status(1'b0, 1'b0, 17'd0);
			end
		join

		// Overflow: third frame finds the FIFO full
		send_frame(1'b1);
		send_frame(1'b1);
		send_frame(1'b0);
		expect_status(1'b1, 1'b0, 17'd0);
		write_reg(REG_STATUS, 32'h8000_0000);
		expect_status(1'b0, 1'b0, 17'd0);
		read_words(2 * `FRAME_WORDS);
		expect_status(1'b0, 1'b0, 17'd0);

		// Frame alignment: unflagged words are discarded
		apply_reset();
		send_line(1'b0);
		send_line(1'b0);
		send_frame(1'b1);
		read_words(`FRAME_WORDS);
		expect_status(1'b0, 1'b0, 17'd0);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- list.f
+incdir+hw
hw/cam_pkg.sv
hw/dma_pkg.sv
hw/word_stream_if.sv
hw/cam_capture.sv
hw/frame_fifo.sv
hw/dma_reader.sv
hw/cam_dma_top.sv
testbench/tb_cam_dma.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the camera DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timescale 1ns/10ps -f list.f --top-module tb_cam_dma \
	-Mdir obj_dir -o tb_cam_dma > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_cam_dma > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^STATUS: PASS$" "$SIM_LOG"; then
	exit 0
else
	echo "Pass message not found in $SIM_LOG"
	exit 1
fi
